// File: oooCore_config.svh
`ifndef OOO_CORE_CONFIG_SVH
`define OOO_CORE_CONFIG_SVH

// datapath width of every integer result
`define OOO_XLEN 32

// architectural register count
`define OOO_NUM_REGS 16

// each lane is one issue queue feeding one execution unit and one result lane
`define OOO_NUM_IQ 2

`define OOO_IQ_DEPTH 4

// also sets the tag width, since a tag is a reorder buffer index
`define OOO_ROB_DEPTH 8

`endif

// File: oooPkg.sv
`include "oooCore_config.svh"

package oooPkg;

    typedef logic [`OOO_XLEN-1:0] data_t;
    typedef logic [$clog2(`OOO_NUM_REGS)-1:0] regIdx_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] tag_t;

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSll,
        opSrl,
        opMul
    } aluOp_t;

    // when ready is low the value is not yet known and tag names its producer
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        data_t value;
    } operand_t;

    typedef struct packed {
        aluOp_t   op;
        tag_t     dest;
        operand_t srcA;
        operand_t srcB;
    } iqEntry_t;

endpackage

// File: oooIfs.sv
`timescale 1ns/1ps

// one micro-op per cycle from dispatch into a single issue queue
interface dispatchIf import oooPkg::*; ();
    logic     valid;
    iqEntry_t entry;
    logic     full;

    modport source (output valid, output entry, input full);
    modport sink (input valid, input entry, output full);
endinterface

// reorder buffer slot allocation, tag is the current tail
interface allocIf import oooPkg::*; ();
    logic    alloc;
    regIdx_t destReg;
    tag_t    tag;
    logic    full;

    modport requester (
        output alloc,
        output destReg,
        input  tag,
        input  full
    );
    modport provider (
        input  alloc,
        input  destReg,
        output tag,
        output full
    );
endinterface

// one result broadcast lane, each strobe lasts a single cycle
interface resultIf import oooPkg::*; ();
    logic  valid;
    tag_t  tag;
    data_t data;

    modport producer (output valid, output tag, output data);
    modport listener (input valid, input tag, input data);
endinterface

// File: dispatchStage.sv
`timescale 1ns/1ps
`include "oooCore_config.svh"

module dispatchStage import oooPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      inValid,
    input  aluOp_t    inOp,
    input  regIdx_t   inDest,
    input  regIdx_t   inSrcA,
    input  regIdx_t   inSrcB,
    input  logic      inUseImm,
    input  data_t     inImm,
    output logic      inReady,
    dispatchIf.source iq [`OOO_NUM_IQ],
    allocIf.requester rob,
    resultIf.listener res [`OOO_NUM_IQ]
);

    localparam int SelW = (`OOO_NUM_IQ > 1) ? $clog2(`OOO_NUM_IQ) : 1;

    data_t    regValue [`OOO_NUM_REGS];
    logic     regPending [`OOO_NUM_REGS];
    tag_t     regTag [`OOO_NUM_REGS];

    logic     resValid [`OOO_NUM_IQ];
    tag_t     resTag [`OOO_NUM_IQ];
    data_t    resData [`OOO_NUM_IQ];
    logic     iqFull [`OOO_NUM_IQ];

    logic [SelW-1:0] selIq;
    logic     accept;
    iqEntry_t newEntry;

    genvar g;
    generate
        for (g = 0; g < `OOO_NUM_IQ; g++) begin : gLane
            assign resValid[g] = res[g].valid;
            assign resTag[g] = res[g].tag;
            assign resData[g] = res[g].data;
            assign iqFull[g] = iq[g].full;
            assign iq[g].valid = accept && (selIq == SelW'(g));
            assign iq[g].entry = newEntry;
        end
    endgenerate

    // micro-ops are spread over the queues by their reorder buffer tag
    assign selIq = SelW'(rob.tag % `OOO_NUM_IQ);
    assign inReady = !rob.full && !iqFull[selIq];
    assign accept = inValid && inReady;

    assign rob.alloc = accept;
    assign rob.destReg = inDest;

    // a result broadcast in this very cycle is not in the table yet, so take it from the bus
    function automatic operand_t readSrc(regIdx_t idx);
        operand_t src;
        src.ready = !regPending[idx];
        src.tag = regTag[idx];
        src.value = regValue[idx];
        for (int l = 0; l < `OOO_NUM_IQ; l++) begin
            if (regPending[idx] && resValid[l] && resTag[l] == regTag[idx]) begin
                src.ready = 1'b1;
                src.value = resData[l];
            end
        end
        return src;
    endfunction

    always_comb begin
        newEntry.op = inOp;
        newEntry.dest = rob.tag;
        newEntry.srcA = readSrc(inSrcA);
        if (inUseImm) begin
            newEntry.srcB.ready = 1'b1;
            newEntry.srcB.tag = '0;
            newEntry.srcB.value = inImm;
        end else begin
            newEntry.srcB = readSrc(inSrcB);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int r = 0; r < `OOO_NUM_REGS; r++) begin
                regValue[r] <= '0;
                regPending[r] <= 1'b0;
                regTag[r] <= '0;
            end
        end else begin
            // only the newest producer of a register may write it back
            for (int r = 0; r < `OOO_NUM_REGS; r++) begin
                for (int l = 0; l < `OOO_NUM_IQ; l++) begin
                    if (regPending[r] && resValid[l] && resTag[l] == regTag[r]) begin
                        regValue[r] <= resData[l];
                        regPending[r] <= 1'b0;
                    end
                end
            end
            if (accept) begin
                regPending[inDest] <= 1'b1;
                regTag[inDest] <= rob.tag;
            end
        end
    end

endmodule

// File: issueQueue.sv
`timescale 1ns/1ps
`include "oooCore_config.svh"

module issueQueue import oooPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    dispatchIf.sink   disp,
    resultIf.listener res [`OOO_NUM_IQ],
    output logic      issueValid,
    output iqEntry_t  issueEntry
);

    localparam int IdxW = $clog2(`OOO_IQ_DEPTH);
    localparam int CntW = $clog2(`OOO_IQ_DEPTH + 1);

    // slots below count are occupied, slot 0 holds the oldest micro-op
    iqEntry_t slots [`OOO_IQ_DEPTH];
    iqEntry_t woken [`OOO_IQ_DEPTH];
    iqEntry_t nextSlots [`OOO_IQ_DEPTH];
    logic [CntW-1:0] count;
    logic [CntW-1:0] nextCount;
    logic [IdxW-1:0] selIdx;

    logic     resValid [`OOO_NUM_IQ];
    tag_t     resTag [`OOO_NUM_IQ];
    data_t    resData [`OOO_NUM_IQ];

    genvar g;
    generate
        for (g = 0; g < `OOO_NUM_IQ; g++) begin : gLane
            assign resValid[g] = res[g].valid;
            assign resTag[g] = res[g].tag;
            assign resData[g] = res[g].data;
        end
    endgenerate

    assign disp.full = (count == CntW'(`OOO_IQ_DEPTH));

    function automatic operand_t snoop(operand_t src);
        operand_t upd;
        upd = src;
        for (int l = 0; l < `OOO_NUM_IQ; l++) begin
            if (!src.ready && resValid[l] && resTag[l] == src.tag) begin
                upd.ready = 1'b1;
                upd.value = resData[l];
            end
        end
        return upd;
    endfunction

    always_comb begin
        for (int i = 0; i < `OOO_IQ_DEPTH; i++) begin
            woken[i] = slots[i];
            woken[i].srcA = snoop(slots[i].srcA);
            woken[i].srcB = snoop(slots[i].srcB);
        end
    end

    // walk from the top so the lowest ready slot wins
    always_comb begin
        issueValid = 1'b0;
        selIdx = '0;
        for (int i = `OOO_IQ_DEPTH - 1; i >= 0; i--) begin
            if (CntW'(i) < count && slots[i].srcA.ready && slots[i].srcB.ready) begin
                issueValid = 1'b1;
                selIdx = IdxW'(i);
            end
        end
    end

    assign issueEntry = slots[selIdx];

    always_comb begin
        nextSlots = woken;
        nextCount = count;
        if (issueValid) begin
            for (int i = 0; i < `OOO_IQ_DEPTH - 1; i++) begin
                if (IdxW'(i) >= selIdx) begin
                    nextSlots[i] = woken[i + 1];
                end
            end
            nextCount = count - 1'b1;
        end
        if (disp.valid) begin
            nextSlots[nextCount[IdxW-1:0]] = disp.entry;
            nextCount = nextCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else begin
            count <= nextCount;
        end
    end

    always_ff @(posedge clk) begin
        slots <= nextSlots;
    end

endmodule

// File: aluPipe.sv
`timescale 1ns/1ps

module aluPipe import oooPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic            issueValid,
    input  iqEntry_t        issueEntry,
    resultIf.producer       res
);

    logic   s1Valid;
    aluOp_t s1Op;
    tag_t   s1Tag;
    data_t  s1A;
    data_t  s1B;
    data_t  aluOut;
    logic   s2Valid;
    tag_t   s2Tag;
    data_t  s2Data;

    always_comb begin
        case (s1Op)
            opAdd:   aluOut = s1A + s1B;
            opSub:   aluOut = s1A - s1B;
            opAnd:   aluOut = s1A & s1B;
            opOr:    aluOut = s1A | s1B;
            opXor:   aluOut = s1A ^ s1B;
            opSll:   aluOut = s1A << s1B[4:0];
            opSrl:   aluOut = s1A >> s1B[4:0];
            // product is truncated to the low word
            opMul:   aluOut = s1A * s1B;
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            s1Valid <= issueValid;
            s2Valid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Op <= issueEntry.op;
        s1Tag <= issueEntry.dest;
        s1A <= issueEntry.srcA.value;
        s1B <= issueEntry.srcB.value;
        s2Tag <= s1Tag;
        s2Data <= aluOut;
    end

    assign res.valid = s2Valid;
    assign res.tag = s2Tag;
    assign res.data = s2Data;

endmodule

// File: reorderBuffer.sv
`timescale 1ns/1ps
`include "oooCore_config.svh"

module reorderBuffer import oooPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    allocIf.provider  alloc,
    resultIf.listener res [`OOO_NUM_IQ],
    output logic      commitValid,
    output tag_t      commitTag,
    output regIdx_t   commitReg,
    output data_t     commitData
);

    localparam int CntW = $clog2(`OOO_ROB_DEPTH + 1);

    regIdx_t entryReg [`OOO_ROB_DEPTH];
    data_t   entryValue [`OOO_ROB_DEPTH];
    logic    entryDone [`OOO_ROB_DEPTH];
    tag_t    head;
    tag_t    tail;
    logic [CntW-1:0] count;

    logic    resValid [`OOO_NUM_IQ];
    tag_t    resTag [`OOO_NUM_IQ];
    data_t   resData [`OOO_NUM_IQ];

    genvar g;
    generate
        for (g = 0; g < `OOO_NUM_IQ; g++) begin : gLane
            assign resValid[g] = res[g].valid;
            assign resTag[g] = res[g].tag;
            assign resData[g] = res[g].data;
        end
    endgenerate

    function automatic tag_t nextPtr(tag_t ptr);
        return (ptr == tag_t'(`OOO_ROB_DEPTH - 1)) ? tag_t'(0) : ptr + 1'b1;
    endfunction

    assign alloc.tag = tail;
    assign alloc.full = (count == CntW'(`OOO_ROB_DEPTH));

    // the head retires once its result has been written back
    assign commitValid = (count != '0) && entryDone[head];
    assign commitTag = head;
    assign commitReg = entryReg[head];
    assign commitData = entryValue[head];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < `OOO_ROB_DEPTH; i++) begin
                entryDone[i] <= 1'b0;
            end
        end else begin
            if (alloc.alloc) begin
                entryDone[tail] <= 1'b0;
                tail <= nextPtr(tail);
            end
            for (int l = 0; l < `OOO_NUM_IQ; l++) begin
                if (resValid[l]) begin
                    entryDone[resTag[l]] <= 1'b1;
                end
            end
            if (commitValid) begin
                head <= nextPtr(head);
            end
            count <= count + CntW'(alloc.alloc) - CntW'(commitValid);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.alloc) begin
            entryReg[tail] <= alloc.destReg;
        end
        for (int l = 0; l < `OOO_NUM_IQ; l++) begin
            if (resValid[l]) begin
                entryValue[resTag[l]] <= resData[l];
            end
        end
    end

endmodule

// File: oooCore.sv
`timescale 1ns/1ps
`include "oooCore_config.svh"

module oooCore import oooPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  aluOp_t  inOp,
    input  regIdx_t inDest,
    input  regIdx_t inSrcA,
    input  regIdx_t inSrcB,
    input  logic    inUseImm,
    input  data_t   inImm,
    output logic    inReady,
    output logic    commitValid,
    output tag_t    commitTag,
    output regIdx_t commitReg,
    output data_t   commitData
);

    dispatchIf dispBus [`OOO_NUM_IQ] ();
    allocIf    allocBus ();
    resultIf   resBus [`OOO_NUM_IQ] ();

    dispatchStage dispatch (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inOp(inOp),
        .inDest(inDest),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .inUseImm(inUseImm),
        .inImm(inImm),
        .inReady(inReady),
        .iq(dispBus),
        .rob(allocBus),
        .res(resBus)
    );

    reorderBuffer rob (
        .clk(clk),
        .rstN(rstN),
        .alloc(allocBus),
        .res(resBus),
        .commitValid(commitValid),
        .commitTag(commitTag),
        .commitReg(commitReg),
        .commitData(commitData)
    );

    // every lane pairs one queue with its own unit and result lane
    genvar g;
    generate
        for (g = 0; g < `OOO_NUM_IQ; g++) begin : gLane
            logic     issueValid;
            iqEntry_t issueEntry;

            issueQueue iq (
                .clk(clk),
                .rstN(rstN),
                .disp(dispBus[g]),
                .res(resBus),
                .issueValid(issueValid),
                .issueEntry(issueEntry)
            );

            aluPipe alu (
                .clk(clk),
                .rstN(rstN),
                .issueValid(issueValid),
                .issueEntry(issueEntry),
                .res(resBus[g])
            );
        end
    endgenerate

endmodule

// File: tbOooCore.sv
`timescale 1ns/1ps
`include "oooCore_config.svh"

module tbOooCore import oooPkg::*; ();

    localparam int NumTests = 4;

    typedef struct packed {
        aluOp_t  op;
        regIdx_t dest;
        regIdx_t srcA;
        regIdx_t srcB;
        logic    useImm;
        data_t   imm;
    } uop_t;

    logic    clk;
    logic    rstN;
    logic    inValid;
    aluOp_t  inOp;
    regIdx_t inDest;
    regIdx_t inSrcA;
    regIdx_t inSrcB;
    logic    inUseImm;
    data_t   inImm;
    logic    inReady;
    logic    commitValid;
    tag_t    commitTag;
    regIdx_t commitReg;
    data_t   commitData;

    uop_t    prog [$];
    int      testEnd [NumTests];
    string   testName [NumTests];
    data_t   archReg [`OOO_NUM_REGS];
    regIdx_t expReg [$];
    data_t   expData [$];
    regIdx_t wantReg;
    data_t   wantData;
    tag_t    wantTag;
    int      commitCount;
    int      errorCount;
    int      cycleCount;
    int      timeoutLimit;

    oooCore u_dut (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inOp(inOp),
        .inDest(inDest),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .inUseImm(inUseImm),
        .inImm(inImm),
        .inReady(inReady),
        .commitValid(commitValid),
        .commitTag(commitTag),
        .commitReg(commitReg),
        .commitData(commitData)
    );

    always #4 clk = ~clk;

    // arithmetic wraps at 32 bits and shifts use the low 5 bits of b
    function automatic data_t expectedResult(aluOp_t op, data_t a, data_t b);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opSll:   return a << b[4:0];
            opSrl:   return a >> b[4:0];
            opMul:   return a * b;
            default: return '0;
        endcase
    endfunction

    task automatic reportError(input string msg);
        $display("** Error @%0t: %s", $time, msg);
        errorCount++;
    endtask

    task automatic addUop(input aluOp_t op, input regIdx_t dest, input regIdx_t srcA,
                          input regIdx_t srcB, input logic useImm, input data_t imm);
        uop_t u;
        u.op = op;
        u.dest = dest;
        u.srcA = srcA;
        u.srcB = srcB;
        u.useImm = useImm;
        u.imm = imm;
        prog.push_back(u);
    endtask

    task automatic buildTables();
        regIdx_t prev;
        regIdx_t dest;
        // r1 and r2 hold the operands of the independent micro-ops
        addUop(opAdd, 4'd1, 4'd0, 4'd0, 1'b1, 32'h1234_5678);
        addUop(opAdd, 4'd2, 4'd0, 4'd0, 1'b1, 32'h0000_0013);
        for (int k = 0; k < 8; k++) begin
            addUop(aluOp_t'(k), regIdx_t'(4 + k), 4'd1, 4'd2, 1'b0, 32'h0);
            addUop(aluOp_t'(k), regIdx_t'(12 + k % 4), 4'd1, 4'd0, 1'b1, 32'hf0f0_0005);
        end
        testEnd[0] = prog.size();
        testName[0] = "every-op";

        addUop(opAdd, 4'd3, 4'd0, 4'd0, 1'b1, 32'h0000_0007);
        prev = 4'd3;
        for (int i = 0; i < 11; i++) begin
            dest = regIdx_t'(1 + i % 5);
            addUop(aluOp_t'(i % 8), dest, prev, prev, (i % 2) == 1,
                   32'h9e37_79b9 + data_t'(i));
            prev = dest;
        end
        testEnd[1] = prog.size();
        testName[1] = "chain";

        addUop(opAdd, 4'd7, 4'd0, 4'd0, 1'b1, 32'd11);
        addUop(opAdd, 4'd7, 4'd0, 4'd0, 1'b1, 32'd22);
        addUop(opAdd, 4'd7, 4'd7, 4'd0, 1'b1, 32'd5);
        addUop(opMul, 4'd7, 4'd7, 4'd7, 1'b0, 32'd0);
        addUop(opXor, 4'd8, 4'd7, 4'd0, 1'b1, 32'h0000_00ff);
        addUop(opAdd, 4'd7, 4'd8, 4'd0, 1'b1, 32'd1);
        addUop(opOr,  4'd9, 4'd7, 4'd8, 1'b0, 32'd0);
        addUop(opSub, 4'd8, 4'd9, 4'd7, 1'b0, 32'd0);
        testEnd[2] = prog.size();
        testName[2] = "hazards";

        for (int n = 0; n < 200; n++) begin
            addUop(aluOp_t'($urandom_range(7, 0)), regIdx_t'($urandom_range(15, 0)),
                   regIdx_t'($urandom_range(15, 0)), regIdx_t'($urandom_range(15, 0)),
                   $urandom_range(1, 0) == 1, $urandom());
        end
        testEnd[3] = prog.size();
        testName[3] = "random";
    endtask

    // the golden model runs in program order as each micro-op is offered
    task automatic applyUop(input uop_t u);
        data_t a;
        data_t b;
        data_t r;
        a = archReg[u.srcA];
        b = u.useImm ? u.imm : archReg[u.srcB];
        r = expectedResult(u.op, a, b);
        archReg[u.dest] = r;
        expReg.push_back(u.dest);
        expData.push_back(r);
        inValid = 1'b1;
        inOp = u.op;
        inDest = u.dest;
        inSrcA = u.srcA;
        inSrcB = u.srcB;
        inUseImm = u.useImm;
        inImm = u.imm;
    endtask

    task automatic checkReset();
        int errBefore;
        errBefore = errorCount;
        repeat (4) begin
            @(negedge clk);
            if (commitValid) begin
                reportError("commitValid is high after reset");
            end
            if (!inReady) begin
                reportError("inReady is low after reset");
            end
        end
        $display("test reset: %0d errors", errorCount - errBefore);
    endtask

    always @(negedge clk) begin
        if (rstN && commitValid) begin
            if (expData.size() == 0) begin
                reportError($sformatf("commit of tag %0d with no micro-op outstanding",
                                      commitTag));
            end else begin
                wantReg = expReg.pop_front();
                wantData = expData.pop_front();
                wantTag = tag_t'(commitCount % `OOO_ROB_DEPTH);
                if (commitReg !== wantReg) begin
                    reportError($sformatf("commit %0d register r%0d, expected r%0d",
                                          commitCount, commitReg, wantReg));
                end
                if (commitData !== wantData) begin
                    reportError($sformatf("commit %0d data %h, expected %h",
                                          commitCount, commitData, wantData));
                end
                if (commitTag !== wantTag) begin
                    reportError($sformatf("commit %0d tag %0d, expected %0d",
                                          commitCount, commitTag, wantTag));
                end
            end
            commitCount++;
        end
    end

    initial begin
        wait (timeoutLimit != 0);
        while (cycleCount < timeoutLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, %0d commits still missing",
                 cycleCount, prog.size() - commitCount);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int idx;
        int startIdx;
        int errBefore;
        clk = 1'b0;
        rstN = 1'b0;
        inValid = 1'b0;
        inOp = opAdd;
        inDest = '0;
        inSrcA = '0;
        inSrcB = '0;
        inUseImm = 1'b0;
        inImm = '0;
        commitCount = 0;
        errorCount = 0;
        cycleCount = 0;
        timeoutLimit = 0;
        for (int r = 0; r < `OOO_NUM_REGS; r++) begin
            archReg[r] = '0;
        end
        void'($urandom(32'h907e));
        buildTables();
        timeoutLimit = 10 * prog.size() + 100;

        repeat (4) @(posedge clk);
        #1 rstN = 1'b1;
        checkReset();

        idx = 0;
        for (int t = 0; t < NumTests; t++) begin
            errBefore = errorCount;
            startIdx = idx;
            while (idx < testEnd[t]) begin
                @(posedge clk);
                #1;
                if (inReady) begin
                    applyUop(prog[idx]);
                    idx++;
                end else begin
                    inValid = 1'b0;
                end
            end
            @(posedge clk);
            #1 inValid = 1'b0;
            while (commitCount < testEnd[t]) @(posedge clk);
            $display("test %0s: %0d micro-ops, %0d errors", testName[t],
                     testEnd[t] - startIdx, errorCount - errBefore);
        end

        $display("summary: %0d tests, %0d commits, %0d errors",
                 NumTests + 1, commitCount, errorCount);
        if (errorCount == 0 && expData.size() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: oooCore.f
+incdir+.
oooPkg.sv
oooIfs.sv
dispatchStage.sv
issueQueue.sv
aluPipe.sv
reorderBuffer.sv
oooCore.sv
tbOooCore.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbOooCore
FILELIST  ?= oooCore.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Regression passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: check

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
